/* Makefile */
# Verilator flow for the stored-block deflate testbench
VERILATOR ?= verilator
TOP       ?= deflate_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
SIMFLAGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Test OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv verif/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only when the pass message is in the simulator output
run: compile
	@out="$$(./$(SIM_BIN) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/bit_packer.sv */
//====================
// LSB-first bit packer into 32-bit output words
// Drains and marks the final word after the last field
//====================
`timescale 1ns/1ps
`include "deflate_defs.svh"

module bit_packer (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        field_valid,
	input  deflate_pkg::field_t         field,
	output logic                        out_valid,
	output logic [`DEFL_WORD_BITS-1:0]  out_word,
	output logic                        out_last,
	output logic [`DEFL_BYTES_BITS-1:0] out_bytes,
	output logic                        done
);
	localparam int CNT_BITS   = $clog2(`DEFL_ACC_BITS + 1);
	localparam int BYTES_BITS = `DEFL_BYTES_BITS;
	localparam logic [CNT_BITS-1:0] WORD_CNT = CNT_BITS'(`DEFL_WORD_BITS);

	logic [`DEFL_ACC_BITS-1:0] acc_q;         // Held bits, oldest at bit 0
	logic [`DEFL_ACC_BITS-1:0] acc_in;
	logic [CNT_BITS-1:0]       cnt_q;         // Number of held bits
	logic [CNT_BITS-1:0]       cnt_in;
	logic                      drain_q;       // Last field seen, bits still held
	logic                      last_seen;
	logic                      emit;
	logic                      emit_last;

	// New field lands right above the bits already held
	always_comb begin
		acc_in = acc_q;
		cnt_in = cnt_q;
		if (field_valid) begin
			acc_in = acc_q | ({{(`DEFL_ACC_BITS-`DEFL_FIELD_BITS){1'b0}}, field.bits} << cnt_q);
			cnt_in = cnt_q + CNT_BITS'(field.size);
		end
	end

	assign last_seen = drain_q | (field_valid & field.last);

	// A full word goes out, and after the last field so does a partial one
	assign emit      = (cnt_in >= WORD_CNT) | (last_seen & (cnt_in != '0));
	assign emit_last = last_seen & (cnt_in != '0) & (cnt_in <= WORD_CNT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_q     <= '0;
			cnt_q     <= '0;
			drain_q   <= 1'b0;
			out_valid <= 1'b0;
			out_last  <= 1'b0;
			out_bytes <= BYTES_BITS'(4);
			done      <= 1'b0;
		end else begin
			out_valid <= emit;
			out_last  <= emit_last;
			out_bytes <= emit_last ? BYTES_BITS'(cnt_in >> 3) : BYTES_BITS'(4);  // Stream is byte aligned
			drain_q   <= last_seen & ~emit_last;
			done      <= done | emit_last;                  // Sticky with out_last
			if (emit) begin
				acc_q <= acc_in >> `DEFL_WORD_BITS;
				cnt_q <= emit_last ? '0 : cnt_in - WORD_CNT;
			end else begin
				acc_q <= acc_in;
				cnt_q <= cnt_in;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit)
			out_word <= acc_in[`DEFL_WORD_BITS-1:0];
	end

endmodule

/* design/block_decoder.sv */
//====================
// Input word classifier
// Splits the stream into headers and data words, counts block bytes
//====================
`timescale 1ns/1ps
`include "deflate_defs.svh"

module block_decoder (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   word_valid,
	input  deflate_pkg::in_word_u  word,
	output logic                   dec_valid,
	output deflate_pkg::dec_word_t dec,
	output logic                   protocol_error
);
	import deflate_pkg::*;

	typedef enum logic [1:0] {EXP_HEADER, EXP_DATA, EXP_ENDED} exp_kind_e;

	exp_kind_e                 exp_q;         // Kind of the next legal word
	logic [`DEFL_LEN_BITS-1:0] bytes_left;    // Data bytes still owed by the block
	logic                      final_q;       // BFINAL of the current block
	logic                      gap_q;         // High in the cycle right after a header
	logic                      violation;
	logic                      accept;
	logic [2:0]                nbytes_c;
	dec_word_t                 dec_c;

	// A word in the post-header gap or after the final block is dropped
	assign violation = word_valid & (gap_q | (exp_q == EXP_ENDED));
	assign accept    = word_valid & ~violation;
	assign nbytes_c  = (bytes_left >= 4) ? 3'd4 : bytes_left[2:0];

	always_comb begin
		dec_c           = '0;
		dec_c.word      = word;
		dec_c.kind      = KIND_NONE;
		if (exp_q == EXP_HEADER) begin
			dec_c.kind      = KIND_HEADER;
			dec_c.block_end = (word.hdr.len == '0);   // Empty block ends at its header
			dec_c.is_final  = word.hdr.bfinal;
		end else begin
			dec_c.kind      = KIND_DATA;
			dec_c.nbytes    = nbytes_c;
			dec_c.block_end = (bytes_left <= 4);
			dec_c.is_final  = final_q;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_q          <= EXP_HEADER;
			bytes_left     <= '0;
			final_q        <= 1'b0;
			gap_q          <= 1'b0;
			dec_valid      <= 1'b0;
			protocol_error <= 1'b0;
		end else begin
			dec_valid <= accept;
			gap_q     <= accept & (exp_q == EXP_HEADER);
			if (violation)
				protocol_error <= 1'b1;   // Sticky until reset
			if (accept) begin
				if (exp_q == EXP_HEADER) begin
					bytes_left <= word.hdr.len;
					final_q    <= word.hdr.bfinal;
				end else begin
					bytes_left <= bytes_left - nbytes_c;
				end
				// After the block's last word a header or nothing may follow
				if (dec_c.block_end)
					exp_q <= dec_c.is_final ? EXP_ENDED : EXP_HEADER;
				else
					exp_q <= EXP_DATA;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			dec <= dec_c;
	end

endmodule

/* design/crc32_engine.sv */
//====================
// CRC-32 over up to four bytes per cycle
//====================
`timescale 1ns/1ps
`include "deflate_defs.svh"

module crc32_engine (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       crc_valid,
	input  logic [`DEFL_WORD_BITS-1:0] crc_data,
	input  logic [2:0]                 crc_nbytes,
	output logic [`DEFL_WORD_BITS-1:0] crc_out
);
	localparam int NUM_BYTES = `DEFL_WORD_BITS / 8;

	logic [`DEFL_WORD_BITS-1:0] crc_q;        // Running remainder, not yet inverted
	logic [`DEFL_WORD_BITS-1:0] crc_next;

	// Byte 0 goes through first, bytes past crc_nbytes are skipped
	always_comb begin
		logic [`DEFL_WORD_BITS-1:0] c;
		c = crc_q;
		for (int i = 0; i < NUM_BYTES; i++) begin
			if (i < crc_nbytes) begin
				c[7:0] = c[7:0] ^ crc_data[i*8 +: 8];
				for (int b = 0; b < 8; b++)
					c = c[0] ? ((c >> 1) ^ `DEFL_CRC_POLY) : (c >> 1);  // Reflected shift
			end
		end
		crc_next = c;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			crc_q <= `DEFL_CRC_INIT;
		else if (crc_valid)
			crc_q <= crc_next;    // Holds between strobes
	end

	assign crc_out = crc_q ^ `DEFL_CRC_INIT;  // Final XOR with all ones

endmodule

/* design/deflate_pkg.sv */
//====================
// Shared types of the stored-block deflate compressor
// Input word union, word kind enum, decoded word and bit field structs
//====================
`include "deflate_defs.svh"

package deflate_pkg;

	// Header word layout, bfinal sits at bit 24 and LEN in the low half
	typedef struct packed {
		logic [`DEFL_WORD_BITS-26:0]    unused_hi;
		logic                           bfinal;
		logic [23-`DEFL_LEN_BITS:0]     unused_mid;
		logic [`DEFL_LEN_BITS-1:0]      len;
	} hdr_view_t;

	// The same input word seen as a header or as four data bytes
	typedef union packed {
		hdr_view_t                              hdr;
		logic [`DEFL_WORD_BITS/8-1:0][7:0]      data;  // Byte 0 is the lowest
	} in_word_u;

	typedef enum logic [1:0] {
		KIND_NONE   = 2'd0,
		KIND_HEADER = 2'd1,
		KIND_DATA   = 2'd2
	} word_kind_e;

	// One classified input word from the decoder
	typedef struct packed {
		word_kind_e kind;
		in_word_u   word;
		logic [2:0] nbytes;       // Valid bytes of a data word
		logic       block_end;    // Last word of its block
		logic       is_final;     // Block carries BFINAL
	} dec_word_t;

	// Bit field for the packer, LSB first
	typedef struct packed {
		logic [`DEFL_FIELD_BITS-1:0] bits;
		logic [`DEFL_SIZE_BITS-1:0]  size;
		logic                        last;    // Final field of the stream
	} field_t;

endpackage

/* design/deflate_stored_top.sv */
//====================
// Stored-block deflate compressor top
// Decoder, sequencer and packer in a row
//====================
`timescale 1ns/1ps
`include "deflate_defs.svh"

module deflate_stored_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        word_valid,
	input  deflate_pkg::in_word_u       word,
	output logic                        out_valid,
	output logic [`DEFL_WORD_BITS-1:0]  out_word,
	output logic                        out_last,
	output logic [`DEFL_BYTES_BITS-1:0] out_bytes,
	output logic                        done,
	output logic                        protocol_error
);
	import deflate_pkg::*;

	logic      dec_valid;     // Decoder to sequencer
	dec_word_t dec;
	logic      field_valid;   // Sequencer to packer
	field_t    field;

	block_decoder block_decoder_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.word_valid     (word_valid),
		.word           (word),
		.dec_valid      (dec_valid),
		.dec            (dec),
		.protocol_error (protocol_error)
	);

	stored_sequencer stored_sequencer_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.dec_valid   (dec_valid),
		.dec         (dec),
		.field_valid (field_valid),
		.field       (field)
	);

	bit_packer bit_packer_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.field_valid (field_valid),
		.field       (field),
		.out_valid   (out_valid),
		.out_word    (out_word),
		.out_last    (out_last),
		.out_bytes   (out_bytes),
		.done        (done)
	);

endmodule

/* design/stored_sequencer.sv */
//====================
// Stored-block field builder
// Header, data and trailer fields, ISIZE and the CRC-32 instance
//====================
`timescale 1ns/1ps
`include "deflate_defs.svh"

module stored_sequencer (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   dec_valid,
	input  deflate_pkg::dec_word_t dec,
	output logic                   field_valid,
	output deflate_pkg::field_t    field
);
	import deflate_pkg::*;

	typedef enum logic [1:0] {SEQ_STREAM, SEQ_CRC, SEQ_ISIZE} seq_state_e;

	localparam logic [`DEFL_SIZE_BITS-1:0] HDR_SIZE  = `DEFL_FIELD_BITS;
	localparam logic [`DEFL_SIZE_BITS-1:0] WORD_SIZE = `DEFL_WORD_BITS;

	seq_state_e                 state_q;
	logic [`DEFL_WORD_BITS-1:0] isize_q;      // Sum of all LEN values, mod 2^32
	logic [`DEFL_WORD_BITS-1:0] crc_value;
	logic [`DEFL_WORD_BITS-1:0] data_masked;
	logic                       crc_valid;
	logic                       trailer_go;
	logic                       field_valid_c;
	field_t                     field_c;

	assign crc_valid  = dec_valid & (dec.kind == KIND_DATA);
	assign trailer_go = dec_valid & dec.block_end & dec.is_final;  // Last word of the final block

	crc32_engine crc32_engine_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.crc_valid  (crc_valid),
		.crc_data   (dec.word.data),
		.crc_nbytes (dec.nbytes),
		.crc_out    (crc_value)
	);

	// Bytes past nbytes are cleared so the packer can OR fields together
	always_comb begin
		for (int i = 0; i < `DEFL_WORD_BITS/8; i++)
			data_masked[i*8 +: 8] = (i < dec.nbytes) ? dec.word.data[i] : 8'h00;
	end

	//====================
	// Field select
	//====================
	always_comb begin
		field_c       = '0;
		field_valid_c = 1'b0;
		if (dec_valid && dec.kind == KIND_HEADER) begin
			// BFINAL then BTYPE 00 padded to the byte, LEN and NLEN above it
			field_valid_c = 1'b1;
			field_c.bits  = {~dec.word.hdr.len, dec.word.hdr.len, 7'b0, dec.word.hdr.bfinal};
			field_c.size  = HDR_SIZE;
		end else if (dec_valid && dec.kind == KIND_DATA) begin
			field_valid_c                     = 1'b1;
			field_c.bits[`DEFL_WORD_BITS-1:0] = data_masked;
			field_c.size                      = {dec.nbytes, 3'b000};
		end else if (state_q == SEQ_CRC) begin
			field_valid_c                     = 1'b1;
			field_c.bits[`DEFL_WORD_BITS-1:0] = crc_value;   // Already covers the last data word
			field_c.size                      = WORD_SIZE;
		end else if (state_q == SEQ_ISIZE) begin
			field_valid_c                     = 1'b1;
			field_c.bits[`DEFL_WORD_BITS-1:0] = isize_q;
			field_c.size                      = WORD_SIZE;
			field_c.last                      = 1'b1;        // Ends the stream
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= SEQ_STREAM;
			isize_q     <= '0;
			field_valid <= 1'b0;
		end else begin
			field_valid <= field_valid_c;
			if (dec_valid && dec.kind == KIND_HEADER)
				isize_q <= isize_q + dec.word.hdr.len;
			// Two-step trailer, CRC first and ISIZE after it
			if (trailer_go)
				state_q <= SEQ_CRC;
			else if (state_q == SEQ_CRC)
				state_q <= SEQ_ISIZE;
			else if (state_q == SEQ_ISIZE)
				state_q <= SEQ_STREAM;
		end
	end

	always_ff @(posedge clk) begin
		if (field_valid_c)
			field <= field_c;
	end

endmodule

/* include/deflate_defs.svh */
//====================
// Width and constant macros for the stored-block deflate datapath
// Word, field, accumulator and byte-count widths plus the CRC-32 constants
//====================
`ifndef DEFLATE_DEFS_SVH
`define DEFLATE_DEFS_SVH

`define DEFL_WORD_BITS   32            // Input and output word width
`define DEFL_LEN_BITS    16            // LEN and NLEN of a stored block

// Header byte plus LEN plus NLEN is the widest field in one cycle
`define DEFL_FIELD_BITS  40
`define DEFL_SIZE_BITS   6             // Field size, 0 to 40 bits
`define DEFL_ACC_BITS    72            // Packer accumulator

// Reflected ISO 3309 polynomial
`define DEFL_CRC_POLY    32'hEDB8_8320
`define DEFL_CRC_INIT    32'hFFFF_FFFF // Also used as the final XOR

// Valid bytes of an output word, 1 to 4
`define DEFL_BYTES_BITS  3

`endif

/* sources.f */
+incdir+include
design/deflate_pkg.sv
design/block_decoder.sv
design/crc32_engine.sv
design/stored_sequencer.sv
design/bit_packer.sv
design/deflate_stored_top.sv
verif/tb_clock_gen.sv
verif/deflate_asserts.sv
verif/deflate_tb.sv

/* verif/deflate_asserts.sv */
//====================
// Concurrent checks on the top-level output strobes
// Bound into the stored-block compressor top
//====================
`timescale 1ns/1ps
`include "deflate_defs.svh"

module deflate_asserts (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        out_valid,
	input logic                        out_last,
	input logic [`DEFL_BYTES_BITS-1:0] out_bytes,
	input logic                        done,
	input logic                        protocol_error
);
	int fail_count = 0;   // Read by the testbench when the trace is done

	// The final word is always a real output word
	last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
		out_last |-> out_valid)
		else begin
			fail_count = fail_count + 1;
			$error("out_last seen without out_valid");
		end

	full_word_bytes: assert property (@(posedge clk) disable iff (!rst_n)
		!out_last |-> (out_bytes == 3'd4))   // Only the last word may be partial
		else begin
			fail_count = fail_count + 1;
			$error("out_bytes is not 4 on a word that is not the last");
		end

	done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> done)
		else begin
			fail_count = fail_count + 1;
			$error("done fell while out of reset");
		end

	// Reset keeps every strobe and flag low
	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> (!out_valid && !out_last && !done && !protocol_error))
		else begin
			fail_count = fail_count + 1;
			$error("Output activity while rst_n is low");
		end

endmodule

bind deflate_stored_top deflate_asserts deflate_asserts_i (
	.clk            (clk),
	.rst_n          (rst_n),
	.out_valid      (out_valid),
	.out_last       (out_last),
	.out_bytes      (out_bytes),
	.done           (done),
	.protocol_error (protocol_error)
);

/* verif/deflate_tb.sv */
//====================
// Testbench for the stored-block deflate compressor
// Trace reader, word driver, output monitor, checks and watchdog
//====================
`timescale 1ns/1ps
`include "deflate_defs.svh"

module deflate_tb;
	import deflate_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int SETTLE     = 4;         // Cycles to catch stray words after done

	logic                        clk;
	logic                        rst_n;
	logic                        rst_req;
	logic                        word_valid;
	in_word_u                    word;
	logic                        out_valid;
	logic [`DEFL_WORD_BITS-1:0]  out_word;
	logic                        out_last;
	logic [`DEFL_BYTES_BITS-1:0] out_bytes;
	logic                        done;
	logic                        protocol_error;

	// Trace lines in file order
	bit                          line_is_in[$];
	logic [`DEFL_WORD_BITS-1:0]  line_val[$];
	int                          line_num[$];   // Idle cycles or valid bytes, -1 is a random gap
	bit                          line_perr[$];
	string                       line_name[$];
	int                          trace_lines = 0;
	int                          seed;

	// Words captured from the DUT
	logic [`DEFL_WORD_BITS-1:0]  got_word[$];
	logic [`DEFL_BYTES_BITS-1:0] got_bytes[$];
	bit                          got_last[$];
	bit                          got_done[$];   // Done flag seen with each word

	tb_clock_gen tb_clock_gen_i (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

	deflate_stored_top deflate_stored_top_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.word_valid     (word_valid),
		.word           (word),
		.out_valid      (out_valid),
		.out_word       (out_word),
		.out_last       (out_last),
		.out_bytes      (out_bytes),
		.done           (done),
		.protocol_error (protocol_error)
	);

	// Outputs change on the rising edge, so the falling edge sees them settled
	always @(negedge clk) begin
		if (rst_n && out_valid) begin
			got_word.push_back(out_word);
			got_bytes.push_back(out_bytes);
			got_last.push_back(out_last);
			got_done.push_back(done);
		end
	end

	always @(negedge clk) begin
		if (deflate_stored_top_i.deflate_asserts_i.fail_count != 0)
			abort_run("A bound assertion on the DUT outputs failed");
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %h, actual %h", what, expected, actual);
			abort_run("DUT output differs from the trace");
		end
	endtask

	// One strobe on a falling edge, then the idle cycles the trace asks for
	task automatic send_word(input logic [`DEFL_WORD_BITS-1:0] value, input int idle);
		word_valid = 1'b1;
		word       = value;
		@(negedge clk);
		word_valid = 1'b0;
		repeat (idle) @(negedge clk);
	endtask

	//====================
	// Trace file
	//====================
	task automatic load_trace();
		int                         fd;
		int                         n;
		int                         num;
		int                         perr;
		string                      text;
		string                      kind;
		string                      tok;
		string                      name;
		logic [`DEFL_WORD_BITS-1:0] value;
		fd = $fopen("verif/stored_trace.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open the trace file verif/stored_trace.txt");
		end else begin
			while ($fgets(text, fd) != 0) begin
				n = $sscanf(text, "%s", kind);
				if (n < 1 || kind == "#")
					continue;                   // Blank line or column notes
				if (kind == "I") begin
					n = $sscanf(text, "%s %h %s", kind, value, tok);
					num = -1;                   // The r token asks for a random gap
					if (tok != "r")
						n = n + $sscanf(tok, "%d", num) - 1;
					perr = 0;
					name = "";
				end else begin
					n = $sscanf(text, "%s %h %d %d %s", kind, value, num, perr, name) - 2;
				end
				if (n != 3 || (kind != "I" && kind != "E"))
					abort_run($sformatf("Malformed trace line: %s", text));
				line_is_in.push_back(kind == "I");
				line_val.push_back(value);
				line_num.push_back(num);
				line_perr.push_back(perr != 0);
				line_name.push_back(name);
			end
			$fclose(fd);
			trace_lines = line_val.size();
			if (trace_lines == 0)
				abort_run("The trace file holds no test lines");
		end
	endtask

	//====================
	// One test: reset, drive its input words, compare the captured words
	//====================
	task automatic run_test(input int first, input int mid, input int stop);
		string name;
		int    idle;
		if (mid == stop)
			abort_run("A test in the trace has no expected words");
		name = line_name[mid];
		@(negedge clk);
		rst_req = 1'b1;                         // Each test is a stream of its own
		@(posedge rst_n);
		rst_req = 1'b0;
		got_word.delete();
		got_bytes.delete();
		got_last.delete();
		got_done.delete();
		for (int i = first; i < mid; i++) begin
			idle = line_num[i];
			if (idle < 0)
				idle = 1 + ($unsigned($random(seed)) % 6);   // Longer than the zero minimum
			send_word(line_val[i], idle);
		end
		while (!done)
			@(negedge clk);                     // The watchdog bounds this wait
		repeat (SETTLE) @(negedge clk);
		check_value($sformatf("%s word count", name), stop - mid, got_word.size());
		for (int k = 0; k < stop - mid; k++) begin
			check_value($sformatf("%s word %0d", name, k), line_val[mid+k], got_word[k]);
			check_value($sformatf("%s out_bytes %0d", name, k), line_num[mid+k], got_bytes[k]);
			check_value($sformatf("%s out_last %0d", name, k), mid + k == stop - 1, got_last[k]);
			// Done rises together with the final word and not before it
			check_value($sformatf("%s done %0d", name, k), mid + k == stop - 1, got_done[k]);
		end
		check_value($sformatf("%s protocol_error", name), line_perr[stop-1], protocol_error);
	endtask

	initial begin
		int idx;
		int first;
		int mid;
		rst_req    = 1'b0;
		word_valid = 1'b0;
		word       = '0;
		seed       = 32'h718d_b468;
		load_trace();
		@(posedge rst_n);                       // Power-on reset from the clock module
		idx = 0;
		while (idx < trace_lines) begin
			first = idx;
			while (idx < trace_lines && line_is_in[idx])
				idx++;
			mid = idx;
			while (idx < trace_lines && !line_is_in[idx])
				idx++;
			run_test(first, mid, idx);
		end
		// Failed bound assertions also fail the run
		if (deflate_stored_top_i.deflate_asserts_i.fail_count == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			abort_run($sformatf("%0d assertion failures during the run",
				deflate_stored_top_i.deflate_asserts_i.fail_count));
		end
	end

	// Watchdog sized from the trace length
	initial begin
		wait (trace_lines > 0);
		#((trace_lines + 200) * CLK_PERIOD);
		abort_run("Watchdog expired before the DUT finished the trace");
	end

endmodule

/* verif/stored_trace.txt */
# I <input word, hex> <idle cycles after it, r for a random gap>
# E <output word, hex> <valid bytes> <protocol_error at end> <test name>
I 01000005 1
I 6C6C6568 0
I AABBCC6F 0
E FA000501 4 0 single_block
E 6C6568FF 4 0 single_block
E A6866F6C 4 0 single_block
E 00053610 4 0 single_block
E 00000000 2 0 single_block
I 00000006 1
I 34333231 0
I DEAD3635 0
I 01000003 1
I 55393837 0
E F9000600 4 0 two_blocks
E 333231FF 4 0 two_blocks
E 01363534 4 0 two_blocks
E FFFC0003 4 0 two_blocks
E 26393837 4 0 two_blocks
E 09CBF439 4 0 two_blocks
E 00000000 3 0 two_blocks
I 00000003 1
I 77636261 0
I 01000000 1
E FC000300 4 0 empty_final
E 636261FF 4 0 empty_final
E FF000001 4 0 empty_final
E 2441C2FF 4 0 empty_final
E 00000335 4 0 empty_final
E 00000000 1 0 empty_final
I 00000006 1
I 34333231 r
I DEAD3635 r
I 01000003 1
I 55393837 r
E F9000600 4 0 random_gaps
E 333231FF 4 0 random_gaps
E 01363534 4 0 random_gaps
E FFFC0003 4 0 random_gaps
E 26393837 4 0 random_gaps
E 09CBF439 4 0 random_gaps
E 00000000 3 0 random_gaps
I 01000005 1
I 6C6C6568 0
I AABBCC6F 2
I 12345678 0
E FA000501 4 1 after_final
E 6C6568FF 4 1 after_final
E A6866F6C 4 1 after_final
E 00053610 4 1 after_final
E 00000000 2 1 after_final

/* verif/tb_clock_gen.sv */
//====================
// Testbench clock and reset
// 20 ns clock, reset low for 4 cycles at start and on request
//====================
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD     = 20,
	parameter int RST_CYCLES = 4
) (
	input  logic rst_req,          // Rising edge reruns the reset sequence
	output logic clk,
	output logic rst_n
);
	initial clk = 1'b0;
	always #(PERIOD/2) clk = ~clk;

	always begin
		rst_n = 1'b0;                  // Asserted right away, the DUT reset is asynchronous
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;                  // Released on a falling edge, away from the DUT edge
		@(posedge rst_req);
	end

endmodule
